// File: rtl/zports_pkg.sv
////////////////////
// port map of the kept Spectrum ports, low address byte only
// 7FFD layout is read two ways, std 128K and Pentagon 1M
////////////////////
package zports_pkg;

	////////////////////
	// low address byte of each port
	////////////////////
	localparam logic [7:0] PORT_FE    = 8'hFE; // border, keys, tape
	localparam logic [7:0] PORT_F6    = 8'hF6; // alias of FE
	localparam logic [7:0] PORT_FD    = 8'hFD; // 7FFD paging, FFFD/BFFD AY
	localparam logic [7:0] PORT_F7    = 8'hF7; // EFF7 paging
	localparam logic [7:0] PORT_KJOY  = 8'h1F; // kempston joystick
	localparam logic [7:0] PORT_CFG   = 8'hBF; // shadow, romrw, nmi
	localparam logic [7:0] PORT_CFGRD = 8'hBE; // nmi clear, readback

	////////////////////
	// BE readback selector on a[11:8]
	////////////////////
	localparam logic [3:0] SEL_7FFD = 4'hA; // raw 7FFD
	localparam logic [3:0] SEL_EFF7 = 4'hB; // raw EFF7

	// one 7FFD byte, two decodings
	typedef union packed
	{
		struct packed
		{
			logic [1:0] spare;  // unused in 128K mode
			logic       lock48; // freezes 7FFD when 1M blocked
			logic       rom;    // rom select
			logic       screen; // shadow screen
			logic [2:0] page;   // ram page at C000
		} std128;
		struct packed
		{
			logic [2:0] page_hi; // extra page bits of 1M mode
			logic       rom;
			logic       screen;
			logic [2:0] page_lo;
		} pent1m;
	} p7ffd_t;

endpackage

// File: rtl/io_strobe.sv
////////////////////
// one zclk pulse per Z80 io access, long cycles give one strobe
////////////////////
`timescale 1ns/1ps

module io_strobe
(
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic iowr_lvl; // io write level on the bus
	logic iord_lvl;
	logic iowr_seen; // level as seen at last edge
	logic iord_seen;

	assign iowr_lvl = ~(iorq_n | wr_n);
	assign iord_lvl = ~(iorq_n | rd_n);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_seen <= 1'b0;
			iord_seen <= 1'b0;
			port_wr   <= 1'b0;
			port_rd   <= 1'b0;
		end
		else
		begin
			iowr_seen <= iowr_lvl;
			iord_seen <= iord_lvl;
			port_wr   <= iowr_lvl & ~iowr_seen; // first low sample only
			port_rd   <= iord_lvl & ~iord_seen;
		end
	end

	// Z80 never reads and writes in one io cycle
	a_no_rd_wr: assert property (@(posedge zclk) disable iff (!rst_n) !(port_wr && port_rd));

endmodule

// File: rtl/port_decode.sv
////////////////////
// combinational decode of the low address byte
// 1F and F7 vanish while shadow is on
////////////////////
`timescale 1ns/1ps

module port_decode
(
	input  logic [15:0] a,
	input  logic        shadow,
	input  logic        port_wr,
	input  logic        port_rd,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic        porthit,
	output logic        external_port,
	output logic        fe_we,
	output logic        fd_we,
	output logic        eff7_we,
	output logic        cfg_we,
	output logic        clr_nmi,
	output logic        ay_bc1,
	output logic        ay_bdir
);

	logic [7:0] loa;
	logic       wr_ok;   // clean write strobe
	logic       hit_fe;
	logic       hit_fd;
	logic       pre_bc1;
	logic       pre_bdir;

	assign loa    = a[7:0];
	assign hit_fe = (loa == zports_pkg::PORT_FE) || (loa == zports_pkg::PORT_F6);
	assign hit_fd = (loa == zports_pkg::PORT_FD);

	// a write strobe counts only with no read strobe riding along
	assign wr_ok = port_wr & ~port_rd;

	////////////////////
	// hits
	////////////////////
	always_comb
	begin
		porthit = hit_fe || hit_fd ||
		          (loa == zports_pkg::PORT_CFG) || (loa == zports_pkg::PORT_CFGRD) ||
		          ((loa == zports_pkg::PORT_KJOY) && !shadow) || // joystick off in shadow
		          ((loa == zports_pkg::PORT_F7) && !shadow);
	end

	assign external_port = hit_fd & a[15]; // FFFD/BFFD live on the AY

	////////////////////
	// write enables, one cycle each
	////////////////////
	assign fe_we   = hit_fe & wr_ok;
	assign fd_we   = hit_fd & ~a[15] & wr_ok; // 7FFD only
	assign eff7_we = (loa == zports_pkg::PORT_F7) & a[8] & ~a[12] & ~shadow & wr_ok;
	assign cfg_we  = (loa == zports_pkg::PORT_CFG) & wr_ok;
	assign clr_nmi = (loa == zports_pkg::PORT_CFGRD) & wr_ok; // BE write ends nmi

	////////////////////
	// AY bus control
	////////////////////
	always_comb
	begin
		pre_bc1  = 1'b0;
		pre_bdir = 1'b0;
		if (hit_fd && a[15:14] == 2'b11) // FFFD register select/read
		begin
			pre_bc1  = 1'b1;
			pre_bdir = 1'b1;
		end
		else if (hit_fd && a[15:14] == 2'b10) // BFFD data write
			pre_bdir = 1'b1;
	end

	assign ay_bc1  = pre_bc1 & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = pre_bdir & ~iorq_n & ~wr_n;

endmodule

// File: rtl/paging_regs.sv
////////////////////
// 7FFD and EFF7, EFF7 bit 2 blocks 1M mode and arms the 128K lock
////////////////////
`timescale 1ns/1ps

module paging_regs
(
	input  logic                zclk,
	input  logic                rst_n,
	input  logic [7:0]          din,
	input  logic                fd_we,
	input  logic                eff7_we,
	output zports_pkg::p7ffd_t  p7ffd_raw,
	output logic [7:0]          peff7_raw,
	output logic [7:0]          p7ffd,
	output logic [7:0]          peff7,
	output logic [5:0]          pent1m_page,
	output logic                pent1m_rom,
	output logic                pent1m_1m_on,
	output logic                pent1m_ram0_0
);

	zports_pkg::p7ffd_t p7ffd_int;
	logic [7:0]         peff7_int;
	logic               block1m; // 1M off, 128K compatible
	logic               locked;

	assign block1m = peff7_int[2];
	assign locked  = p7ffd_int.std128.lock48 & block1m; // 48K lock only without 1M

	////////////////////
	// registers
	////////////////////
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_int <= '0;
		else if (fd_we && !locked)
			p7ffd_int <= din;
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_int <= 8'h00;
		else if (eff7_we)
			peff7_int <= din; // 0 p16c, 2 block1m, 3 ram0, 4 turbo off
	end

	////////////////////
	// outputs
	////////////////////
	assign p7ffd_raw = p7ffd_int;
	assign peff7_raw = peff7_int;

	// top page bits hidden in 128K mode
	assign p7ffd = {block1m ? 3'b000 : p7ffd_int.pent1m.page_hi,
	                p7ffd_int.pent1m.rom, p7ffd_int.pent1m.screen, p7ffd_int.pent1m.page_lo};

	assign peff7 = block1m ? {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]}
	                       : peff7_int;

	assign pent1m_page   = {p7ffd_int.pent1m.page_hi, p7ffd_int.pent1m.page_lo};
	assign pent1m_rom    = p7ffd_int.pent1m.rom;
	assign pent1m_1m_on  = ~peff7_int[2];
	assign pent1m_ram0_0 = peff7_int[3];

	// lock holds across any 7FFD write
	a_lock_hold: assert property (@(posedge zclk) disable iff (!rst_n) locked |=> $stable(p7ffd_int));

endmodule

// File: rtl/config_ports.sv
////////////////////
// border from FE, BF config bits, BE write clears nmi
////////////////////
`timescale 1ns/1ps

module config_ports
(
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        fe_we,
	input  logic        cfg_we,
	input  logic        clr_nmi,
	output logic [3:0]  border,
	output logic        shadow_en,
	output logic        romrw_en,
	output logic        set_nmi
);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= 4'h0;
		else if (fe_we)
			border <= {~a[3], din[2:0]}; // bright from inverted a3
	end

	////////////////////
	// port BF
	////////////////////
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else if (cfg_we) // config write beats the clear
		begin
			shadow_en <= din[0];
			romrw_en  <= din[1];
			set_nmi   <= din[3];
		end
		else if (clr_nmi)
			set_nmi <= 1'b0;
	end

	a_nmi_clr: assert property (@(posedge zclk) disable iff (!rst_n)
		(clr_nmi && !cfg_we) |=> !set_nmi);

endmodule

// File: rtl/read_mux.sv
////////////////////
// byte back to the Z80, FF for anything not ours
////////////////////
`timescale 1ns/1ps

module read_mux
(
	input  logic [15:0]        a,
	input  logic               shadow,
	input  logic               porthit,
	input  logic               external_port,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               tape_read,
	input  logic [4:0]         keys_in,
	input  logic [4:0]         kj_in,
	input  zports_pkg::p7ffd_t p7ffd_raw,
	input  logic [7:0]         peff7_raw,
	input  logic               shadow_en,
	input  logic               romrw_en,
	input  logic               set_nmi,
	output logic [7:0]         dout,
	output logic               dataout
);

	logic [7:0] portbe_mux;

	// BE readback, raw values without the 1M masking
	always_comb
	begin
		if (a[11:8] == zports_pkg::SEL_7FFD)
			portbe_mux = p7ffd_raw;
		else if (a[11:8] == zports_pkg::SEL_EFF7)
			portbe_mux = peff7_raw;
		else
			portbe_mux = 8'hFF;
	end

	always_comb
	begin
		case (a[7:0])
			zports_pkg::PORT_FE, zports_pkg::PORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			zports_pkg::PORT_KJOY:
				dout = shadow ? 8'hFF : {3'b000, kj_in}; // no joystick in shadow
			zports_pkg::PORT_CFG:
				dout = {4'b0000, set_nmi, 1'b0, romrw_en, shadow_en};
			zports_pkg::PORT_CFGRD:
				dout = portbe_mux;
			default:
				dout = 8'hFF;
		endcase
	end

	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port; // AY drives its own reads

endmodule

// File: rtl/zports.sv
////////////////////
// Spectrum io ports on zclk, plain strobes and no wait
////////////////////
`timescale 1ns/1ps

module zports
(
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,
	input  logic        tape_read,
	input  logic [4:0]  keys_in,
	input  logic [4:0]  kj_in,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic        external_port,
	output logic        ay_bc1,
	output logic        ay_bdir,
	output logic [3:0]  border,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        clr_nmi
);

	logic               port_wr;
	logic               port_rd;
	logic               shadow;    // dos rom or forced by BF
	logic               shadow_en;
	logic               fe_we;
	logic               fd_we;
	logic               eff7_we;
	logic               cfg_we;
	zports_pkg::p7ffd_t p7ffd_raw;
	logic [7:0]         peff7_raw;

	assign shadow = dos | shadow_en;

	io_strobe u_io_strobe (.zclk, .rst_n, .iorq_n, .rd_n, .wr_n, .port_wr, .port_rd);

	port_decode u_port_decode (.a, .shadow, .port_wr, .port_rd, .iorq_n, .rd_n, .wr_n,
		.porthit, .external_port, .fe_we, .fd_we, .eff7_we, .cfg_we, .clr_nmi,
		.ay_bc1, .ay_bdir);

	paging_regs u_paging_regs (.zclk, .rst_n, .din, .fd_we, .eff7_we, .p7ffd_raw, .peff7_raw,
		.p7ffd, .peff7, .pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0);

	config_ports u_config_ports (.zclk, .rst_n, .a, .din, .fe_we, .cfg_we, .clr_nmi,
		.border, .shadow_en, .romrw_en, .set_nmi);

	read_mux u_read_mux (.a, .shadow, .porthit, .external_port, .iorq_n, .rd_n, .tape_read,
		.keys_in, .kj_in, .p7ffd_raw, .peff7_raw, .shadow_en, .romrw_en, .set_nmi,
		.dout, .dataout);

endmodule

// File: sim/tb_zports.sv
////////////////////
// reads sim/zports_vectors.txt relative to the project root
// stops at the first mismatch
////////////////////
`timescale 1ns/1ps

module tb_zports;

	// one parsed vector line
	typedef struct packed
	{
		logic [7:0]  op; // R, W or C
		logic [15:0] a;
		logic [7:0]  din;
		logic        dos;
		logic        tape;
		logic [4:0]  keys;
		logic [4:0]  kj;
		logic [7:0]  dout;
		logic        dataout;
		logic        porthit;
		logic        ext;
		logic        bc1;
		logic        bdir;
		logic [3:0]  border;
		logic [7:0]  p7ffd;
		logic [7:0]  peff7;
		logic [5:0]  page;
		logic        on1m;
		logic        nmi;
		logic        romrw;
	} vec_t;

	logic zclk, rst_n, iorq_n, rd_n, wr_n, dos, tape_read;
	logic [15:0] a;
	logic [7:0]  din, dout, p7ffd, peff7;
	logic [4:0]  keys_in, kj_in;
	logic        dataout, porthit, external_port, ay_bc1, ay_bdir;
	logic [3:0]  border;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom, pent1m_1m_on, pent1m_ram0_0, romrw_en, set_nmi, clr_nmi;

	vec_t vecs[$];
	int   vec_idx = 0;
	int   cycle_cnt = 0;
	int   cycle_limit = 0; // set once the vectors are counted

	zports u_zports (.*);

	initial
	begin
		zclk = 1'b0;
		forever #20 zclk = ~zclk; // 40 ns
	end

	////////////////////
	// error handling
	////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp_val,
		input logic [7:0] act_val);
		if (act_val !== exp_val)
			abort_run($sformatf("Fail %s expected %h got %h at vector %0d",
				name, exp_val, act_val, vec_idx));
	endtask

	task automatic check_bit(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val)
			abort_run($sformatf("Fail %s expected %h got %h at vector %0d",
				name, exp_val, act_val, vec_idx));
	endtask

	task automatic check_nibble(input string name, input logic [3:0] exp_val,
		input logic [3:0] act_val);
		if (act_val !== exp_val)
			abort_run($sformatf("Fail %s expected %h got %h at vector %0d",
				name, exp_val, act_val, vec_idx));
	endtask

	// shows the 1M page split too
	task automatic check_p7ffd(input string name, input zports_pkg::p7ffd_t exp_val,
		input zports_pkg::p7ffd_t act_val);
		if (act_val !== exp_val)
			abort_run($sformatf("Fail %s expected %h got %h (page_hi %h/%h) at vector %0d", name,
				exp_val, act_val, exp_val.pent1m.page_hi, act_val.pent1m.page_hi, vec_idx));
	endtask

	always @(posedge zclk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
			abort_run("timeout, the vectors did not finish within the cycle limit");
	end

	////////////////////
	// vector file
	////////////////////
	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [15:0] f [0:18];
		vec_t        v;
		fd = $fopen("sim/zports_vectors.txt", "r");
		if (fd == 0)
			abort_run("cannot open sim/zports_vectors.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#") // header or blank
					continue;
				n = $sscanf(line.substr(1, line.len() - 1),
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
					f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
				if (n != 19 || !(line[0] == "R" || line[0] == "W" || line[0] == "C"))
					abort_run({"malformed vector line: ", line});
				else
				begin
					v = '{line[0], f[0], f[1][7:0], f[2][0], f[3][0], f[4][4:0], f[5][4:0],
					      f[6][7:0], f[7][0], f[8][0], f[9][0], f[10][0], f[11][0],
					      f[12][3:0], f[13][7:0], f[14][7:0], f[15][5:0], f[16][0],
					      f[17][0], f[18][0]};
					vecs.push_back(v);
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////
	// bus cycle and checks
	////////////////////
	task automatic check_bus(input vec_t v);
		check_bit("porthit", v.porthit, porthit);
		check_bit("external_port", v.ext, external_port);
		check_bit("ay_bc1", v.bc1, ay_bc1);
		check_bit("ay_bdir", v.bdir, ay_bdir);
		if (v.op == "R") // read data only on reads
		begin
			check_byte("dout", v.dout, dout);
			check_bit("dataout", v.dataout, dataout);
		end
	endtask

	task automatic check_regs(input vec_t v);
		check_nibble("border", v.border, border);
		check_p7ffd("p7ffd", v.p7ffd, p7ffd);
		check_byte("peff7", v.peff7, peff7);
		check_byte("pent1m_page", {2'b00, v.page}, {2'b00, pent1m_page});
		check_bit("pent1m_rom", v.p7ffd[4], pent1m_rom); // rom bit never masked
		if (v.op == "R" && v.a[7:0] == 8'hBE && v.a[11:8] == 4'hB)
			check_bit("pent1m_ram0_0", v.dout[3], pent1m_ram0_0); // raw EFF7 on the bus
		else if (v.on1m)
			check_bit("pent1m_ram0_0", v.peff7[3], pent1m_ram0_0); // peff7 unmasked
		check_bit("pent1m_1m_on", v.on1m, pent1m_1m_on);
		check_bit("set_nmi", v.nmi, set_nmi);
		check_bit("romrw_en", v.romrw, romrw_en);
	endtask

	// entered and left on a falling edge
	task automatic run_vector(input vec_t v);
		a         = v.a;
		din       = v.din;
		dos       = v.dos;
		tape_read = v.tape;
		keys_in   = v.keys;
		kj_in     = v.kj;
		if (v.op != "C")
		begin
			iorq_n = 1'b0;
			if (v.op == "W")
				wr_n = 1'b0;
			else
				rd_n = 1'b0;
			@(negedge zclk);
			check_bit("clr_nmi", v.op == "W" && v.a[7:0] == 8'hBE, clr_nmi); // strobe cycle
			@(negedge zclk);
			check_bus(v); // mid low phase
			@(negedge zclk);
			iorq_n = 1'b1;
			rd_n   = 1'b1;
			wr_n   = 1'b1;
			repeat (2) @(negedge zclk); // registers settled by now
		end
		else
			@(negedge zclk);
		check_regs(v);
	endtask

	initial
	begin
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		tape_read = 1'b0;
		keys_in   = 5'h00;
		kj_in     = 5'h00;
		load_vectors();
		cycle_limit = 10 + 6 * vecs.size() + 20; // reset, vectors, slack
		repeat (10) @(negedge zclk);
		rst_n = 1'b1;
		for (vec_idx = 0; vec_idx < vecs.size(); vec_idx++)
			run_vector(vecs[vec_idx]);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: sim/zports_vectors.txt
# op a din dos tape keys kj | dout dataout porthit ext bc1 bdir | border p7ffd peff7 page 1m_on nmi romrw
# op R read, W write, C check only; dout/dataout checked on R, bus columns skipped on C; all hex
# reset values
C 0000 00 0 0 00 00 00 0 0 0 0 0 0 00 00 00 1 0 0
W 00FE 05 0 0 00 00 00 0 1 0 0 0 5 00 00 00 1 0 0
W 00F6 03 0 0 00 00 00 0 1 0 0 0 B 00 00 00 1 0 0
R 00FE 00 0 1 0A 00 CA 1 1 0 0 0 B 00 00 00 1 0 0
R 00F6 00 0 0 15 00 95 1 1 0 0 0 B 00 00 00 1 0 0
W 7FFD 17 0 0 00 00 00 0 1 0 0 0 B 17 00 07 1 0 0
W 7FFD C9 0 0 00 00 00 0 1 0 0 0 B C9 00 31 1 0 0
W EFF7 5F 0 0 00 00 00 0 1 0 0 0 B 09 11 31 0 0 0
W 7FFD 2C 0 0 00 00 00 0 1 0 0 0 B 0C 11 0C 0 0 0
W 7FFD 03 0 0 00 00 00 0 1 0 0 0 B 0C 11 0C 0 0 0
R 0ABE 00 0 0 00 00 2C 1 1 0 0 0 B 0C 11 0C 0 0 0
R 0BBE 00 0 0 00 00 5F 1 1 0 0 0 B 0C 11 0C 0 0 0
R 0CBE 00 0 0 00 00 FF 1 1 0 0 0 B 0C 11 0C 0 0 0
R 001F 00 0 0 00 13 13 1 1 0 0 0 B 0C 11 0C 0 0 0
W 00BF 09 0 0 00 00 00 0 1 0 0 0 B 0C 11 0C 0 1 0
R 001F 00 0 0 00 13 FF 0 0 0 0 0 B 0C 11 0C 0 1 0
W EFF7 00 0 0 00 00 00 0 0 0 0 0 B 0C 11 0C 0 1 0
R 00BF 00 0 0 00 00 09 1 1 0 0 0 B 0C 11 0C 0 1 0
W 00BE 00 0 0 00 00 00 0 1 0 0 0 B 0C 11 0C 0 0 0
R 00BF 00 0 0 00 00 01 1 1 0 0 0 B 0C 11 0C 0 0 0
W 00BF 02 0 0 00 00 00 0 1 0 0 0 B 0C 11 0C 0 0 1
R 001F 00 1 0 00 0C FF 0 0 0 0 0 B 0C 11 0C 0 0 1
W EFF7 00 1 0 00 00 00 0 0 0 0 0 B 0C 11 0C 0 0 1
R 001F 00 0 0 00 0C 0C 1 1 0 0 0 B 0C 11 0C 0 0 1
W EFF7 00 0 0 00 00 00 0 1 0 0 0 B 2C 00 0C 1 0 1
R FFFD 00 0 0 00 00 FF 0 1 1 1 0 B 2C 00 0C 1 0 1
W FFFD 07 0 0 00 00 00 0 1 1 1 1 B 2C 00 0C 1 0 1
W BFFD 55 0 0 00 00 00 0 1 1 0 1 B 2C 00 0C 1 0 1
R 00FF 00 0 0 00 00 FF 0 0 0 0 0 B 2C 00 0C 1 0 1

// File: tb.f
rtl/zports_pkg.sv
rtl/io_strobe.sv
rtl/port_decode.sv
rtl/paging_regs.sv
rtl/config_ports.sv
rtl/read_mux.sv
rtl/zports.sv
sim/tb_zports.sv

// File: run_sim.sh
#!/bin/sh
# build and run the zports testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_zports -Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_zports
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

exit 0
